//--- include/mem_sched_macros.svh
// Sizing macros for the banked memory request scheduler
// Lane, bank, queue and field widths

`ifndef MEM_SCHED_MACROS_SVH
`define MEM_SCHED_MACROS_SVH

// Lanes per core request and memory banks
`define MS_NUM_LANES    4
`define MS_NUM_BANKS    2
`define MS_NUM_BATCHES  (`MS_NUM_LANES / `MS_NUM_BANKS)

// Request queue depth, also the number of read slots
`define MS_QUEUE_SIZE   4

`define MS_ADDR_W       32
`define MS_DATA_W       32
`define MS_CORE_TAG_W   8

`endif

//--- design/mem_sched_pkg.sv
// Shared types for the memory scheduler
// Field typedefs and request/response structs

`default_nettype none

package mem_sched_pkg;

`include "mem_sched_macros.svh"

    typedef logic [`MS_ADDR_W-1:0]                 addr_t;
    typedef logic [`MS_DATA_W-1:0]                 data_t;
    typedef logic [`MS_DATA_W/8-1:0]               byteen_t;
    typedef logic [`MS_NUM_LANES-1:0]              lane_mask_t;
    typedef logic [`MS_NUM_BANKS-1:0]              bank_mask_t;
    typedef logic [`MS_CORE_TAG_W-1:0]             core_tag_t;
    typedef logic [$clog2(`MS_QUEUE_SIZE)-1:0]     slot_t;
    typedef logic [$clog2(`MS_NUM_BATCHES)-1:0]    batch_t;

    // Sent with every bank request, echoed back by the bank
    typedef struct packed {
        batch_t batch;
        slot_t  slot;
    } mem_tag_t;

    typedef struct packed {
        logic                               rw;
        lane_mask_t                         mask;
        byteen_t [`MS_NUM_LANES-1:0]        byteen;
        addr_t   [`MS_NUM_LANES-1:0]        addr;
        data_t   [`MS_NUM_LANES-1:0]        data;
        core_tag_t                          tag;
    } core_req_t;

    // Queue entry: the core tag is parked in the tag table
    typedef struct packed {
        logic                               rw;
        lane_mask_t                         mask;
        byteen_t [`MS_NUM_LANES-1:0]        byteen;
        addr_t   [`MS_NUM_LANES-1:0]        addr;
        data_t   [`MS_NUM_LANES-1:0]        data;
        slot_t                              slot;
    } queued_req_t;

    typedef struct packed {
        logic     rw;
        byteen_t  byteen;
        addr_t    addr;
        data_t    data;
        mem_tag_t mem_tag;
    } bank_req_t;

    typedef struct packed {
        data_t    data;
        mem_tag_t mem_tag;
    } bank_rsp_t;

    typedef struct packed {
        lane_mask_t                         mask;
        data_t [`MS_NUM_LANES-1:0]          data;
        core_tag_t                          tag;
    } core_rsp_t;

endpackage

`default_nettype wire

//--- design/req_queue.sv
// Core request FIFO with acceptance rule
// Swaps read tags for slot indices, flags write submission

`timescale 1ns/1ps
`default_nettype none

`include "mem_sched_macros.svh"

module req_queue import mem_sched_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  core_req_t   req,
    output logic        req_ready,
    input  slot_t       slot_free,
    input  logic        slots_full,
    input  logic        slots_idle,
    output logic        alloc,
    output core_tag_t   alloc_tag,
    output lane_mask_t  alloc_mask,
    output queued_req_t head,
    output logic        head_valid,
    input  logic        pop,
    output logic        req_empty,
    output logic        write_notify
);

    localparam int CNT_W = $clog2(`MS_QUEUE_SIZE + 1);

    queued_req_t      mem [`MS_QUEUE_SIZE];
    queued_req_t      entry;
    slot_t            wr_ptr;
    slot_t            rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;

    assign full      = (count == CNT_W'(`MS_QUEUE_SIZE));
    // Reads also need a free slot
    assign req_ready = !full && (req.rw || !slots_full);
    assign push      = req_valid && req_ready;

    assign alloc      = push && !req.rw;
    assign alloc_tag  = req.tag;
    assign alloc_mask = req.mask;

    always_comb begin
        entry.rw     = req.rw;
        entry.mask   = req.mask;
        entry.byteen = req.byteen;
        entry.addr   = req.addr;
        entry.data   = req.data;
        entry.slot   = slot_free;
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= entry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + slot_t'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + slot_t'(1);
            end
            if (push && !pop) begin
                count <= count + CNT_W'(1);
            end else if (pop && !push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    assign head         = mem[rd_ptr];
    assign head_valid   = (count != '0);
    assign write_notify = pop && head.rw;
    assign req_empty    = !head_valid && slots_idle;

endmodule

`default_nettype wire

//--- design/tag_table.sv
// Read slot allocator
// Holds core tag and original lane mask per outstanding read

`timescale 1ns/1ps
`default_nettype none

`include "mem_sched_macros.svh"

module tag_table import mem_sched_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       alloc,
    input  core_tag_t  alloc_tag,
    input  lane_mask_t alloc_mask,
    output slot_t      slot_free,
    output logic       slots_full,
    output logic       slots_idle,
    input  logic       release_en,
    input  slot_t      release_slot,
    input  slot_t      lookup_slot,
    output core_tag_t  lookup_tag,
    output lane_mask_t lookup_mask
);

    logic [`MS_QUEUE_SIZE-1:0] in_use;
    core_tag_t                 tag_mem  [`MS_QUEUE_SIZE];
    lane_mask_t                mask_mem [`MS_QUEUE_SIZE];

    // Lowest free slot wins
    always_comb begin
        slot_free = '0;
        for (int i = `MS_QUEUE_SIZE - 1; i >= 0; i--) begin
            if (!in_use[i]) begin
                slot_free = slot_t'(i);
            end
        end
    end

    assign slots_full = &in_use;
    assign slots_idle = ~|in_use;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_use <= '0;
        end else begin
            if (alloc) begin
                in_use[slot_free] <= 1'b1;
            end
            if (release_en) begin
                in_use[release_slot] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_mem[slot_free]  <= alloc_tag;
            mask_mem[slot_free] <= alloc_mask;
        end
    end

    assign lookup_tag  = tag_mem[lookup_slot];
    assign lookup_mask = mask_mem[lookup_slot];

endmodule

`default_nettype wire

//--- design/batch_sequencer.sv
// Batch sequencer for the queue head
// Slices lanes into per-bank requests, one batch at a time

`timescale 1ns/1ps
`default_nettype none

`include "mem_sched_macros.svh"

module batch_sequencer import mem_sched_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  queued_req_t                   head,
    input  logic                          head_valid,
    output logic                          pop,
    output bank_mask_t                    mem_req_valid,
    output bank_req_t [`MS_NUM_BANKS-1:0] mem_req,
    input  bank_mask_t                    mem_req_ready
);

    batch_t     batch_idx;
    batch_t     last_batch;
    bank_mask_t sent_mask;
    bank_mask_t sent_next;
    bank_mask_t cur_mask;
    logic       batch_done;

    // Per-bank slice of the current batch
    always_comb begin
        int lane;
        for (int j = 0; j < `MS_NUM_BANKS; j++) begin
            lane = int'(batch_idx) * `MS_NUM_BANKS + j;
            cur_mask[j]               = head.mask[lane];
            mem_req[j].rw             = head.rw;
            mem_req[j].byteen         = head.byteen[lane];
            mem_req[j].addr           = head.addr[lane];
            mem_req[j].data           = head.data[lane];
            mem_req[j].mem_tag.batch  = batch_idx;
            mem_req[j].mem_tag.slot   = head.slot;
        end
    end

    // Highest batch that has any enabled lane
    always_comb begin
        last_batch = '0;
        for (int b = 0; b < `MS_NUM_BATCHES; b++) begin
            if (|head.mask[b*`MS_NUM_BANKS +: `MS_NUM_BANKS]) begin
                last_batch = batch_t'(b);
            end
        end
    end

    assign mem_req_valid = {`MS_NUM_BANKS{head_valid}} & cur_mask & ~sent_mask;
    assign sent_next     = sent_mask | (mem_req_valid & mem_req_ready);
    // Empty batches finish without any transfer
    assign batch_done    = head_valid && ((cur_mask & ~sent_next) == '0);
    assign pop           = batch_done && (batch_idx == last_batch);

    always_ff @(posedge clk) begin
        if (reset) begin
            batch_idx <= '0;
            sent_mask <= '0;
        end else if (batch_done) begin
            sent_mask <= '0;
            batch_idx <= pop ? batch_t'(0) : batch_idx + batch_t'(1);
        end else if (head_valid) begin
            sent_mask <= sent_next;
        end
    end

endmodule

`default_nettype wire

//--- design/bank_rsp_arb.sv
// Fixed-priority bank response select
// Lowest-numbered valid bank goes first

`timescale 1ns/1ps
`default_nettype none

`include "mem_sched_macros.svh"

module bank_rsp_arb import mem_sched_pkg::*; (
    input  bank_mask_t                    mem_rsp_valid,
    input  bank_rsp_t [`MS_NUM_BANKS-1:0] mem_rsp,
    output bank_mask_t                    mem_rsp_ready,
    output logic                          sel_valid,
    output bank_rsp_t                     sel_rsp,
    output logic                          sel_bank,
    input  logic                          sel_ready
);

    always_comb begin
        sel_bank = 1'b0;
        for (int j = `MS_NUM_BANKS - 1; j >= 0; j--) begin
            if (mem_rsp_valid[j]) begin
                sel_bank = 1'(j);
            end
        end
    end

    assign sel_valid = |mem_rsp_valid;
    assign sel_rsp   = mem_rsp[sel_bank];

    // Only the winner sees ready
    always_comb begin
        mem_rsp_ready = '0;
        mem_rsp_ready[sel_bank] = sel_valid && sel_ready;
    end

endmodule

`default_nettype wire

//--- design/rsp_merge.sv
// Response merge per read slot
// Remaining-lane tracking, word gathering, registered core response

`timescale 1ns/1ps
`default_nettype none

`include "mem_sched_macros.svh"

module rsp_merge import mem_sched_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       sel_valid,
    input  bank_rsp_t  sel_rsp,
    input  logic       sel_bank,
    output logic       sel_ready,
    input  logic       alloc,
    input  lane_mask_t alloc_mask,
    input  slot_t      slot_free,
    output slot_t      lookup_slot,
    input  core_tag_t  lookup_tag,
    input  lane_mask_t lookup_mask,
    output logic       release_en,
    output slot_t      release_slot,
    output logic       rsp_valid,
    output core_rsp_t  rsp,
    input  logic       rsp_ready
);

    lane_mask_t                  rem_mask   [`MS_QUEUE_SIZE];
    data_t [`MS_NUM_LANES-1:0]   data_store [`MS_QUEUE_SIZE];
    data_t [`MS_NUM_LANES-1:0]   store_next;
    lane_mask_t                  lane_bit;
    lane_mask_t                  rem_next;
    slot_t                       slot;
    int                          lane;
    logic                        complete;
    logic                        fire;
    logic                        out_free;

    assign slot = sel_rsp.mem_tag.slot;
    assign lane = int'(sel_rsp.mem_tag.batch) * `MS_NUM_BANKS + int'(sel_bank);

    assign lane_bit = lane_mask_t'(1) << lane;
    assign rem_next = rem_mask[slot] & ~lane_bit;
    assign complete = (rem_next == '0);

    always_comb begin
        store_next       = data_store[slot];
        store_next[lane] = sel_rsp.data;
    end

    // A completing word needs room in the output register
    assign out_free  = !rsp_valid || rsp_ready;
    assign sel_ready = !complete || out_free;
    assign fire      = sel_valid && sel_ready;

    assign lookup_slot  = slot;
    assign release_en   = fire && complete;
    assign release_slot = slot;

    always_ff @(posedge clk) begin
        if (alloc) begin
            rem_mask[slot_free] <= alloc_mask;
        end
        if (fire) begin
            rem_mask[slot]   <= rem_next;
            data_store[slot] <= store_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (release_en) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (release_en) begin
            rsp.mask <= lookup_mask;
            rsp.data <= store_next;
            rsp.tag  <= lookup_tag;
        end
    end

endmodule

`default_nettype wire

//--- design/mem_sched_top.sv
// Top level of the banked memory request scheduler
// Queue, tag table, sequencer, response select and merge

`timescale 1ns/1ps
`default_nettype none

`include "mem_sched_macros.svh"

module mem_sched_top import mem_sched_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_valid,
    input  core_req_t                     req,
    output logic                          req_ready,
    output logic                          rsp_valid,
    output core_rsp_t                     rsp,
    input  logic                          rsp_ready,
    output bank_mask_t                    mem_req_valid,
    output bank_req_t [`MS_NUM_BANKS-1:0] mem_req,
    input  bank_mask_t                    mem_req_ready,
    input  bank_mask_t                    mem_rsp_valid,
    input  bank_rsp_t [`MS_NUM_BANKS-1:0] mem_rsp,
    output bank_mask_t                    mem_rsp_ready,
    output logic                          write_notify,
    output logic                          req_empty
);

    slot_t       slot_free;
    logic        slots_full;
    logic        slots_idle;
    logic        alloc;
    core_tag_t   alloc_tag;
    lane_mask_t  alloc_mask;
    queued_req_t head;
    logic        head_valid;
    logic        pop;
    logic        release_en;
    slot_t       release_slot;
    slot_t       lookup_slot;
    core_tag_t   lookup_tag;
    lane_mask_t  lookup_mask;
    logic        sel_valid;
    bank_rsp_t   sel_rsp;
    logic        sel_bank;
    logic        sel_ready;

    req_queue req_queue_inst (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .slot_free    (slot_free),
        .slots_full   (slots_full),
        .slots_idle   (slots_idle),
        .alloc        (alloc),
        .alloc_tag    (alloc_tag),
        .alloc_mask   (alloc_mask),
        .head         (head),
        .head_valid   (head_valid),
        .pop          (pop),
        .req_empty    (req_empty),
        .write_notify (write_notify)
    );

    tag_table tag_table_inst (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc),
        .alloc_tag    (alloc_tag),
        .alloc_mask   (alloc_mask),
        .slot_free    (slot_free),
        .slots_full   (slots_full),
        .slots_idle   (slots_idle),
        .release_en   (release_en),
        .release_slot (release_slot),
        .lookup_slot  (lookup_slot),
        .lookup_tag   (lookup_tag),
        .lookup_mask  (lookup_mask)
    );

    batch_sequencer batch_sequencer_inst (
        .clk           (clk),
        .reset         (reset),
        .head          (head),
        .head_valid    (head_valid),
        .pop           (pop),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready)
    );

    bank_rsp_arb bank_rsp_arb_inst (
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready),
        .sel_valid     (sel_valid),
        .sel_rsp       (sel_rsp),
        .sel_bank      (sel_bank),
        .sel_ready     (sel_ready)
    );

    rsp_merge rsp_merge_inst (
        .clk          (clk),
        .reset        (reset),
        .sel_valid    (sel_valid),
        .sel_rsp      (sel_rsp),
        .sel_bank     (sel_bank),
        .sel_ready    (sel_ready),
        .alloc        (alloc),
        .alloc_mask   (alloc_mask),
        .slot_free    (slot_free),
        .lookup_slot  (lookup_slot),
        .lookup_tag   (lookup_tag),
        .lookup_mask  (lookup_mask),
        .release_en   (release_en),
        .release_slot (release_slot),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .rsp_ready    (rsp_ready)
    );

endmodule

`default_nettype wire

//--- tb/mem_model.sv
// Two-bank behavioral memory for the scheduler testbench
// One request per bank at a time, random 0 to 3 cycle read latency

`timescale 1ns/1ps
`default_nettype none

`include "mem_sched_macros.svh"

module mem_model import mem_sched_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  bank_mask_t                    mem_req_valid,
    input  bank_req_t [`MS_NUM_BANKS-1:0] mem_req,
    output bank_mask_t                    mem_req_ready,
    output bank_mask_t                    mem_rsp_valid,
    output bank_rsp_t [`MS_NUM_BANKS-1:0] mem_rsp,
    input  bank_mask_t                    mem_rsp_ready
);

    // Word store indexed by address / 4
    data_t                         store [addr_t];
    bank_mask_t                    busy      = '0;
    bank_mask_t                    rsp_pend  = '0;
    bank_rsp_t [`MS_NUM_BANKS-1:0] rsp_word  = '0;
    logic [1:0]                    delay [`MS_NUM_BANKS];

    function automatic data_t read_word(addr_t addr);
        if (store.exists(addr >> 2)) begin
            return store[addr >> 2];
        end
        // Never written: complement of the address
        return ~addr;
    endfunction

    task automatic write_word(addr_t addr, data_t wdata, byteen_t be);
        data_t word;
        word = read_word(addr);
        for (int b = 0; b < `MS_DATA_W / 8; b++) begin
            if (be[b]) begin
                word[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        store[addr >> 2] = word;
    endtask

    initial begin
        void'($urandom(32'h676e));
    end

    assign mem_req_ready = ~busy;
    assign mem_rsp_valid = rsp_pend;
    assign mem_rsp       = rsp_word;

    always @(posedge clk) begin
        if (reset) begin
            busy     <= '0;
            rsp_pend <= '0;
        end else begin
            for (int j = 0; j < `MS_NUM_BANKS; j++) begin
                if (rsp_pend[j]) begin
                    if (mem_rsp_ready[j]) begin
                        rsp_pend[j] <= 1'b0;
                        busy[j]     <= 1'b0;
                    end
                end else if (busy[j]) begin
                    if (delay[j] == 2'd0) begin
                        rsp_pend[j] <= 1'b1;
                    end else begin
                        delay[j] <= delay[j] - 2'd1;
                    end
                end else if (mem_req_valid[j]) begin
                    if (mem_req[j].rw) begin
                        write_word(mem_req[j].addr, mem_req[j].data, mem_req[j].byteen);
                    end else begin
                        busy[j]             <= 1'b1;
                        delay[j]            <= 2'($urandom % 4);
                        rsp_word[j].data    <= read_word(mem_req[j].addr);
                        rsp_word[j].mem_tag <= mem_req[j].mem_tag;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_mem_sched.sv
// Directed testbench for the banked memory request scheduler
// Clock, reset, test tasks, response capture and summary

`timescale 1ns/1ps
`default_nettype none

`include "mem_sched_macros.svh"

module tb_mem_sched import mem_sched_pkg::*; ();

    logic                          clk;
    logic                          reset;
    logic                          req_valid;
    core_req_t                     req;
    logic                          req_ready;
    logic                          rsp_valid;
    core_rsp_t                     rsp;
    logic                          rsp_ready;
    bank_mask_t                    mem_req_valid;
    bank_req_t [`MS_NUM_BANKS-1:0] mem_req;
    bank_mask_t                    mem_req_ready;
    bank_mask_t                    mem_rsp_valid;
    bank_rsp_t [`MS_NUM_BANKS-1:0] mem_rsp;
    bank_mask_t                    mem_rsp_ready;
    logic                          write_notify;
    logic                          req_empty;

    core_rsp_t rsp_q [$];
    core_req_t sent_q [$];
    data_t     shadow [addr_t];
    int        checks       = 0;
    int        errors       = 0;
    int        notify_count = 0;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    mem_sched_top mem_sched_top_inst (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_ready     (rsp_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready),
        .write_notify  (write_notify),
        .req_empty     (req_empty)
    );

    mem_model mem_model_inst (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready)
    );

    // Handshakes sampled mid-cycle before the transfer edge
    always @(negedge clk) begin
        if (rsp_valid && rsp_ready) begin
            rsp_q.push_back(rsp);
        end
        if (write_notify) begin
            notify_count++;
        end
    end

    function automatic data_t expected_word(addr_t addr);
        if (shadow.exists(addr >> 2)) begin
            return shadow[addr >> 2];
        end
        return ~addr;
    endfunction

    function automatic data_t merge_bytes(data_t old, data_t wdata, byteen_t be);
        data_t word;
        word = old;
        for (int b = 0; b < `MS_DATA_W / 8; b++) begin
            if (be[b]) begin
                word[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return word;
    endfunction

    function automatic core_req_t make_req(logic rw, core_tag_t tag, lane_mask_t mask,
                                           addr_t base);
        core_req_t r;
        r      = '0;
        r.rw   = rw;
        r.tag  = tag;
        r.mask = mask;
        for (int i = 0; i < `MS_NUM_LANES; i++) begin
            r.addr[i]   = base + addr_t'(i) * 32'h104;
            r.byteen[i] = '1;
        end
        return r;
    endfunction

    task automatic check(string name, logic [255:0] got, logic [255:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail at %0t: %s got %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic report_test(string name, int err_start);
        if (errors == err_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_start);
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic send_req(core_req_t r);
        logic taken;
        int   cycles;
        taken     = 1'b0;
        cycles    = 0;
        req       = r;
        req_valid = 1'b1;
        while (!taken && cycles < 50) begin
            @(negedge clk);
            taken = req_ready;
            @(posedge clk);
            #1;
            cycles++;
        end
        req_valid = 1'b0;
        if (!taken) begin
            errors++;
            $display("Timeout: request with tag %h was never accepted", r.tag);
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(req_empty && !rsp_valid) && cycles < 300) begin
            @(negedge clk);
            cycles++;
        end
        if (!(req_empty && !rsp_valid)) begin
            errors++;
            $display("Timeout: scheduler still busy after %0d cycles", cycles);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic compare_rsp(core_rsp_t r, core_req_t q);
        check("rsp.tag", r.tag, q.tag);
        check("rsp.mask", r.mask, q.mask);
        for (int i = 0; i < `MS_NUM_LANES; i++) begin
            if (q.mask[i]) begin
                check($sformatf("rsp.data[%0d] tag %h", i, q.tag), r.data[i],
                      expected_word(q.addr[i]));
            end
        end
    endtask

    // Each response matches exactly one open read by tag
    task automatic match_responses(int expected_count);
        core_rsp_t r;
        int        idx;
        check("response count", rsp_q.size(), expected_count);
        while (rsp_q.size() > 0) begin
            r   = rsp_q.pop_front();
            idx = -1;
            for (int i = 0; i < sent_q.size(); i++) begin
                if (idx < 0 && sent_q[i].tag == r.tag) begin
                    idx = i;
                end
            end
            if (idx < 0) begin
                errors++;
                $display("Response with tag %h matches no open read", r.tag);
            end else begin
                compare_rsp(r, sent_q[idx]);
                sent_q.delete(idx);
            end
        end
        check("reads left without a response", sent_q.size(), 0);
        sent_q.delete();
    endtask

    task automatic full_read();
        core_req_t r;
        int        err_start;
        err_start = errors;
        r = make_req(1'b0, 8'h11, 4'b1111, 32'h0000_0100);
        sent_q.push_back(r);
        send_req(r);
        wait_idle();
        match_responses(1);
        report_test("full_read", err_start);
    endtask

    task automatic sparse_read();
        core_req_t r;
        int        err_start;
        err_start = errors;
        r = make_req(1'b0, 8'h22, 4'b0100, 32'h0000_0800);
        sent_q.push_back(r);
        send_req(r);
        wait_idle();
        match_responses(1);
        report_test("sparse_read", err_start);
    endtask

    task automatic write_then_read();
        core_req_t w;
        core_req_t r;
        int        err_start;
        int        notify_start;
        err_start    = errors;
        notify_start = notify_count;
        w        = make_req(1'b1, 8'h33, 4'b1111, 32'h0000_0a00);
        w.byteen = {4'b0101, 4'b1010, 4'b1100, 4'b0011};
        w.data   = {32'hdead_beef, 32'h1234_5678, 32'h0bad_cafe, 32'h5a5a_a5a5};
        for (int i = 0; i < `MS_NUM_LANES; i++) begin
            shadow[w.addr[i] >> 2] = merge_bytes(expected_word(w.addr[i]), w.data[i],
                                                 w.byteen[i]);
        end
        send_req(w);
        wait_idle();
        check("write_notify pulses", notify_count - notify_start, 1);
        check("responses to a write", rsp_q.size(), 0);
        r = make_req(1'b0, 8'h34, 4'b1111, 32'h0000_0a00);
        sent_q.push_back(r);
        send_req(r);
        wait_idle();
        match_responses(1);
        report_test("write_then_read", err_start);
    endtask

    task automatic overlap();
        core_req_t  r;
        lane_mask_t masks [4];
        int         err_start;
        err_start = errors;
        masks = '{4'b1111, 4'b1010, 4'b0011, 4'b1001};
        for (int i = 0; i < 4; i++) begin
            r = make_req(1'b0, 8'h40 + 8'(i), masks[i], 32'h0000_2000 + 32'(i) * 32'h1000);
            sent_q.push_back(r);
            send_req(r);
        end
        wait_idle();
        match_responses(4);
        report_test("overlap", err_start);
    endtask

    task automatic back_pressure();
        core_req_t r;
        int        err_start;
        int        cycles;
        err_start = errors;
        rsp_ready = 1'b0;
        for (int i = 0; i < 4; i++) begin
            r = make_req(1'b0, 8'h50 + 8'(i), 4'b1111, 32'h0001_0000 + 32'(i) * 32'h1000);
            sent_q.push_back(r);
            send_req(r);
        end
        r = make_req(1'b0, 8'h54, 4'b1111, 32'h0002_0000);
        sent_q.push_back(r);
        req       = r;
        req_valid = 1'b1;
        cycles    = 0;
        @(negedge clk);
        check("req_ready with four reads open", req_ready, 0);
        while (!req_ready && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (!req_ready) begin
            errors++;
            $display("Timeout: fifth read was never accepted");
        end else begin
            // A slot frees only once a read has completed into the output register
            check("rsp_valid when fifth read accepted", rsp_valid, 1);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        // Reads stay open behind the full output register
        check("req_empty while held", req_empty, 0);
        check("rsp_valid while held", rsp_valid, 1);
        rsp_ready = 1'b1;
        wait_idle();
        match_responses(5);
        report_test("back_pressure", err_start);
    endtask

    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        check("rsp_valid after reset", rsp_valid, 0);
        check("mem_req_valid after reset", mem_req_valid, 0);
        check("write_notify after reset", write_notify, 0);
        check("req_empty after reset", req_empty, 1);
        full_read();
        sparse_read();
        write_then_read();
        overlap();
        back_pressure();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
design/mem_sched_pkg.sv
design/req_queue.sv
design/tag_table.sv
design/batch_sequencer.sv
design/bank_rsp_arb.sv
design/rsp_merge.sv
design/mem_sched_top.sv
tb/mem_model.sv
tb/tb_mem_sched.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_mem_sched \
		-Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
